// ==== common/roverPkg.sv ====
`default_nettype none

package roverPkg;

	////////////////////////////////////////////////////////////
	// Data widths
	////////////////////////////////////////////////////////////

	// Accepted level changes in one window
	typedef logic [15:0] countT;

	// Sum of the last AvgDepth window counts
	typedef logic [18:0] rateT;

	// Servo pulse width or period in clock cycles
	typedef logic [20:0] widthT;

	typedef enum logic [1:0] {
		ClassNone  = 2'd0,
		ClassFar   = 2'd1,
		ClassClose = 2'd2
	} beaconClassT;

	////////////////////////////////////////////////////////////
	// Rate classification
	////////////////////////////////////////////////////////////

	localparam int AvgDepth = 8;

	// Far is strictly above this and below CloseThreshold
	localparam int FarThreshold = 25;
	localparam int CloseThreshold = 250;

	////////////////////////////////////////////////////////////
	// Seven-segment patterns
	////////////////////////////////////////////////////////////

	// Active low, bit 6 is segment g and bit 0 is segment a
	localparam logic [6:0] SegC = 7'b1000110;
	localparam logic [6:0] SegF = 7'b0001110;
	localparam logic [6:0] SegBlank = 7'b1111111;

endpackage

`default_nettype wire

// ==== beacon/transitionCounter.sv ====
`timescale 1ns/1ps
`default_nettype none

module transitionCounter #(
	parameter int WindowCycles = 64,
	parameter int DebounceDepth = 3
) (
	input wire logic clock,
	input wire logic arstN,
	input wire logic sensor,
	output roverPkg::countT windowCount,
	output logic windowDone
);

	localparam int WinBits = $clog2(WindowCycles);

	logic [1:0] syncQ;
	logic [DebounceDepth-1:0] shiftQ;
	logic accepted;
	logic levelChange;
	roverPkg::countT runCount;
	roverPkg::countT nextCount;
	logic [WinBits-1:0] winCount;
	logic lastCycle;

	////////////////////////////////////////////////////////////
	// Synchronizer and debounce
	////////////////////////////////////////////////////////////

	// Accept a new level only when every sample agrees on it
	always_comb begin
		if (accepted) begin
			levelChange = ~|shiftQ;
		end else begin
			levelChange = &shiftQ;
		end
	end

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			syncQ <= '0;
			shiftQ <= '0;
			accepted <= 1'b0;
		end else begin
			syncQ <= {syncQ[0], sensor};
			shiftQ <= {shiftQ[DebounceDepth-2:0], syncQ[1]};
			if (levelChange) begin
				accepted <= ~accepted;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Window counting
	////////////////////////////////////////////////////////////

	assign lastCycle = (winCount == WinBits'(WindowCycles - 1));

	// Saturating increment, so a change on the last cycle still counts
	always_comb begin
		nextCount = runCount;
		if (levelChange && (runCount != '1)) begin
			nextCount = runCount + 1'b1;
		end
	end

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			winCount <= '0;
			runCount <= '0;
			windowCount <= '0;
			windowDone <= 1'b0;
		end else begin
			windowDone <= lastCycle;
			if (lastCycle) begin
				winCount <= '0;
				windowCount <= nextCount;
				runCount <= '0;
			end else begin
				winCount <= winCount + 1'b1;
				runCount <= nextCount;
			end
		end
	end

endmodule

`default_nettype wire

// ==== beacon/rateAverager.sv ====
`timescale 1ns/1ps
`default_nettype none

module rateAverager (
	input wire logic clock,
	input wire logic arstN,
	input wire roverPkg::countT windowCount,
	input wire logic windowDone,
	output roverPkg::beaconClassT beaconClass
);

	localparam int PtrBits = $clog2(roverPkg::AvgDepth);

	roverPkg::countT ring [roverPkg::AvgDepth];
	logic [PtrBits-1:0] ptr;
	roverPkg::countT newQ;
	roverPkg::countT oldQ;
	logic updatePending;
	roverPkg::rateT rate;
	roverPkg::rateT sumNext;
	roverPkg::beaconClassT classNext;

	////////////////////////////////////////////////////////////
	// Ring of window counts
	////////////////////////////////////////////////////////////

	// Oldest slot is overwritten, its value kept for the subtract
	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < roverPkg::AvgDepth; i++) begin
				ring[i] <= '0;
			end
			ptr <= '0;
			newQ <= '0;
			oldQ <= '0;
			updatePending <= 1'b0;
		end else begin
			updatePending <= windowDone;
			if (windowDone) begin
				ring[ptr] <= windowCount;
				newQ <= windowCount;
				oldQ <= ring[ptr];
				if (ptr == PtrBits'(roverPkg::AvgDepth - 1)) begin
					ptr <= '0;
				end else begin
					ptr <= ptr + 1'b1;
				end
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Running sum and classification
	////////////////////////////////////////////////////////////

	always_comb begin
		sumNext = rate + roverPkg::rateT'(newQ) - roverPkg::rateT'(oldQ);
		if (sumNext >= roverPkg::CloseThreshold) begin
			classNext = roverPkg::ClassClose;
		end else if (sumNext > roverPkg::FarThreshold) begin
			classNext = roverPkg::ClassFar;
		end else begin
			classNext = roverPkg::ClassNone;
		end
	end

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			rate <= '0;
			beaconClass <= roverPkg::ClassNone;
		end else if (updatePending) begin
			rate <= sumNext;
			beaconClass <= classNext;
		end
	end

endmodule

`default_nettype wire

// ==== shooter/fireSequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module fireSequencer #(
	parameter int HoldCycles = 600,
	parameter roverPkg::widthT RestWidthLeft = 21'd20,
	parameter roverPkg::widthT RestWidthRight = 21'd120,
	parameter roverPkg::widthT FireStep = 21'd40
) (
	input wire logic clock,
	input wire logic arstN,
	input wire roverPkg::beaconClassT classLeft,
	input wire roverPkg::beaconClassT classRight,
	output roverPkg::widthT widthLeft,
	output roverPkg::widthT widthRight
);

	localparam int HoldBits = $clog2(HoldCycles);

	typedef enum logic [1:0] {
		Idle,
		FireLeft,
		FireRight,
		Return
	} stateT;

	stateT state;
	logic [HoldBits-1:0] holdCount;
	logic holdDone;

	assign holdDone = (holdCount == HoldBits'(HoldCycles - 1));

	////////////////////////////////////////////////////////////
	// Firing FSM
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			state <= Idle;
			holdCount <= '0;
		end else begin
			case (state)
				Idle: begin
					holdCount <= '0;
					// Left side wins a tie
					if (classLeft == roverPkg::ClassClose) begin
						state <= FireLeft;
					end else if (classRight == roverPkg::ClassClose) begin
						state <= FireRight;
					end
				end
				FireLeft, FireRight: begin
					if (holdDone) begin
						holdCount <= '0;
						state <= Return;
					end else begin
						holdCount <= holdCount + 1'b1;
					end
				end
				Return: begin
					state <= Idle;
				end
				default: begin
					state <= Idle;
				end
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// Servo widths
	////////////////////////////////////////////////////////////

	// Servos swing in opposite directions, so the step has opposite sign
	always_comb begin
		widthLeft = RestWidthLeft;
		widthRight = RestWidthRight;
		case (state)
			FireLeft: begin
				widthLeft = RestWidthLeft + FireStep;
			end
			FireRight: begin
				widthRight = RestWidthRight - FireStep;
			end
			default: begin
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== shooter/servoPwm.sv ====
`timescale 1ns/1ps
`default_nettype none

module servoPwm #(
	parameter roverPkg::widthT ServoPeriod = 21'd200
) (
	input wire logic clock,
	input wire logic arstN,
	input wire roverPkg::widthT pulseWidth,
	output logic servo
);

	roverPkg::widthT periodCount;
	roverPkg::widthT widthQ;
	logic lastCycle;

	assign lastCycle = (periodCount == ServoPeriod - 1'b1);

	////////////////////////////////////////////////////////////
	// Period counter and width compare
	////////////////////////////////////////////////////////////

	// Width is taken only at period start so no pulse is ever cut short
	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			periodCount <= '0;
			widthQ <= '0;
			servo <= 1'b0;
		end else begin
			if (lastCycle) begin
				periodCount <= '0;
				widthQ <= pulseWidth;
				servo <= (pulseWidth != '0);
			end else begin
				periodCount <= periodCount + 1'b1;
				servo <= ((periodCount + 1'b1) < widthQ);
			end
		end
	end

endmodule

`default_nettype wire

// ==== source/statusDisplay.sv ====
`timescale 1ns/1ps
`default_nettype none

module statusDisplay #(
	parameter int ScanBits = 4
) (
	input wire logic clock,
	input wire logic arstN,
	input wire roverPkg::beaconClassT classLeft,
	input wire roverPkg::beaconClassT classRight,
	output logic [6:0] segments,
	output logic [3:0] anodes
);

	logic [ScanBits-1:0] scanCount;
	logic [1:0] digit;
	logic anyClose;
	logic anyFar;

	assign digit = scanCount[ScanBits-1 -: 2];
	assign anyClose = (classLeft == roverPkg::ClassClose) ||
		(classRight == roverPkg::ClassClose);
	assign anyFar = (classLeft == roverPkg::ClassFar) ||
		(classRight == roverPkg::ClassFar);

	////////////////////////////////////////////////////////////
	// Digit scan
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			scanCount <= '0;
			anodes <= 4'b1110;
			segments <= roverPkg::SegBlank;
		end else begin
			scanCount <= scanCount + 1'b1;
			case (digit)
				2'd0: begin
					anodes <= 4'b1110;
					segments <= anyClose ? roverPkg::SegC : roverPkg::SegBlank;
				end
				2'd1: begin
					anodes <= 4'b1101;
					segments <= anyFar ? roverPkg::SegF : roverPkg::SegBlank;
				end
				2'd2: begin
					anodes <= 4'b1011;
					segments <= roverPkg::SegBlank;
				end
				default: begin
					// Last digit unused
					anodes <= 4'b0111;
					segments <= roverPkg::SegBlank;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== source/beaconShooter.sv ====
`timescale 1ns/1ps
`default_nettype none

module beaconShooter #(
	parameter int WindowCycles = 3437500,
	parameter int DebounceDepth = 5,
	parameter roverPkg::widthT ServoPeriod = 21'd2000000,
	parameter roverPkg::widthT RestWidthLeft = 21'd60000,
	parameter roverPkg::widthT RestWidthRight = 21'd225000,
	parameter roverPkg::widthT FireStep = 21'd55000,
	parameter int HoldCycles = 200000000,
	parameter int ScanBits = 21
) (
	input wire logic clock,
	input wire logic arstN,
	input wire logic sensorLeft,
	input wire logic sensorRight,
	output logic servoLeft,
	output logic servoRight,
	output logic [6:0] segments,
	output logic [3:0] anodes
);

	roverPkg::countT windowCountLeft;
	roverPkg::countT windowCountRight;
	logic windowDoneLeft;
	logic windowDoneRight;
	roverPkg::beaconClassT classLeft;
	roverPkg::beaconClassT classRight;
	roverPkg::widthT widthLeft;
	roverPkg::widthT widthRight;

	////////////////////////////////////////////////////////////
	// Beacon channels
	////////////////////////////////////////////////////////////

	transitionCounter #(
		.WindowCycles(WindowCycles),
		.DebounceDepth(DebounceDepth)
	) counterLeft (
		.clock(clock),
		.arstN(arstN),
		.sensor(sensorLeft),
		.windowCount(windowCountLeft),
		.windowDone(windowDoneLeft)
	);

	transitionCounter #(
		.WindowCycles(WindowCycles),
		.DebounceDepth(DebounceDepth)
	) counterRight (
		.clock(clock),
		.arstN(arstN),
		.sensor(sensorRight),
		.windowCount(windowCountRight),
		.windowDone(windowDoneRight)
	);

	rateAverager averagerLeft (
		.clock(clock),
		.arstN(arstN),
		.windowCount(windowCountLeft),
		.windowDone(windowDoneLeft),
		.beaconClass(classLeft)
	);

	rateAverager averagerRight (
		.clock(clock),
		.arstN(arstN),
		.windowCount(windowCountRight),
		.windowDone(windowDoneRight),
		.beaconClass(classRight)
	);

	////////////////////////////////////////////////////////////
	// Shooter and display
	////////////////////////////////////////////////////////////

	fireSequencer #(
		.HoldCycles(HoldCycles),
		.RestWidthLeft(RestWidthLeft),
		.RestWidthRight(RestWidthRight),
		.FireStep(FireStep)
	) sequencer (
		.clock(clock),
		.arstN(arstN),
		.classLeft(classLeft),
		.classRight(classRight),
		.widthLeft(widthLeft),
		.widthRight(widthRight)
	);

	servoPwm #(
		.ServoPeriod(ServoPeriod)
	) pwmLeft (
		.clock(clock),
		.arstN(arstN),
		.pulseWidth(widthLeft),
		.servo(servoLeft)
	);

	servoPwm #(
		.ServoPeriod(ServoPeriod)
	) pwmRight (
		.clock(clock),
		.arstN(arstN),
		.pulseWidth(widthRight),
		.servo(servoRight)
	);

	statusDisplay #(
		.ScanBits(ScanBits)
	) display (
		.clock(clock),
		.arstN(arstN),
		.classLeft(classLeft),
		.classRight(classRight),
		.segments(segments),
		.anodes(anodes)
	);

endmodule

`default_nettype wire

// ==== verification/beaconShooter_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module beaconShooter_chk #(
	parameter roverPkg::widthT RestWidthLeft = 21'd20,
	parameter roverPkg::widthT RestWidthRight = 21'd120
) (
	input wire logic clock,
	input wire logic arstN,
	input wire logic [3:0] anodes,
	input wire roverPkg::widthT widthLeft,
	input wire roverPkg::widthT widthRight,
	input wire logic windowDoneLeft,
	input wire logic windowDoneRight
);

	////////////////////////////////////////////////////////////
	// Top-level properties
	////////////////////////////////////////////////////////////

	// One digit driven at a time
	anodeOneLow: assert property (@(posedge clock) disable iff (!arstN)
		$onehot(~anodes))
		else $error("anodes 0x%0h does not select exactly one digit", anodes);

	// Only one side fires at a time
	singleSideFire: assert property (@(posedge clock) disable iff (!arstN)
		!((widthLeft != RestWidthLeft) && (widthRight != RestWidthRight)))
		else $error("both servo widths left rest at once");

	windowStrobeLeft: assert property (@(posedge clock) disable iff (!arstN)
		windowDoneLeft |=> !windowDoneLeft)
		else $error("left window strobe lasted two cycles");

	windowStrobeRight: assert property (@(posedge clock) disable iff (!arstN)
		windowDoneRight |=> !windowDoneRight)
		else $error("right window strobe lasted two cycles");

endmodule

bind beaconShooter beaconShooter_chk #(
	.RestWidthLeft(RestWidthLeft),
	.RestWidthRight(RestWidthRight)
) topChecks (
	.clock(clock),
	.arstN(arstN),
	.anodes(anodes),
	.widthLeft(widthLeft),
	.widthRight(widthRight),
	.windowDoneLeft(windowDoneLeft),
	.windowDoneRight(windowDoneRight)
);

`default_nettype wire

// ==== verification/beaconShooterTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module beaconShooterTb;

	localparam int TbWindow = 128;
	localparam int TbDebounce = 3;
	localparam roverPkg::widthT TbPeriod = 21'd200;
	localparam roverPkg::widthT TbRestLeft = 21'd20;
	localparam roverPkg::widthT TbRestRight = 21'd120;
	localparam roverPkg::widthT TbStep = 21'd40;
	localparam int TbHold = 600;
	localparam int TbScan = 4;

	// Rate rule for the classifier
	localparam int RateDepth = 8;
	localparam int FarLimit = 25;
	localparam int CloseLimit = 250;

	// Enough pulses to outlast one hold plus the return
	localparam int MaxPulses = 8;
	localparam string VectorFile = "verification/beaconShooter_vectors.txt";

	logic clock = 1'b0;
	logic arstN = 1'b0;
	logic sensorLeft = 1'b0;
	logic sensorRight = 1'b0;
	logic servoLeft;
	logic servoRight;
	logic [6:0] segments;
	logic [3:0] anodes;

	// Sensor generator state
	int halfLeft = 0;
	int halfRight = 0;
	logic glitchMode = 1'b0;
	int phaseLeft = 0;
	int phaseRight = 0;
	logic levelLeft = 1'b0;
	logic levelRight = 1'b0;
	logic spikeLeft = 1'b0;
	logic spikeRight = 1'b0;
	logic spikeLast = 1'b0;
	integer seed = 32'h79bd_61d9;

	integer fd;
	logic [8*128-1:0] lineText;
	int fields;
	int vecHalfLeft;
	int vecHalfRight;
	int vecWindows;
	int vecClassLeft;
	int vecClassRight;
	int vecGlitch;
	int vectorCount = 0;

	beaconShooter #(
		.WindowCycles(TbWindow),
		.DebounceDepth(TbDebounce),
		.ServoPeriod(TbPeriod),
		.RestWidthLeft(TbRestLeft),
		.RestWidthRight(TbRestRight),
		.FireStep(TbStep),
		.HoldCycles(TbHold),
		.ScanBits(TbScan)
	) UUT (
		.clock(clock),
		.arstN(arstN),
		.sensorLeft(sensorLeft),
		.sensorRight(sensorRight),
		.servoLeft(servoLeft),
		.servoRight(servoRight),
		.segments(segments),
		.anodes(anodes)
	);

	initial begin
		forever #4 clock = ~clock;
	end

	////////////////////////////////////////////////////////////
	// Sensor stimulus
	////////////////////////////////////////////////////////////

	// Square wave per side, single-cycle spikes never back to back
	always @(posedge clock) begin
		spikeLeft = 1'b0;
		spikeRight = 1'b0;
		if (glitchMode && !spikeLast) begin
			spikeLeft = (($random(seed) & 7) == 0);
			spikeRight = (($random(seed) & 7) == 0);
		end
		spikeLast = spikeLeft | spikeRight;
		if (halfLeft != 0) begin
			phaseLeft = phaseLeft + 1;
			if (phaseLeft >= halfLeft) begin
				phaseLeft = 0;
				levelLeft = ~levelLeft;
			end
		end
		if (halfRight != 0) begin
			phaseRight = phaseRight + 1;
			if (phaseRight >= halfRight) begin
				phaseRight = 0;
				levelRight = ~levelRight;
			end
		end
		sensorLeft <= levelLeft ^ spikeLeft;
		sensorRight <= levelRight ^ spikeRight;
	end

	////////////////////////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////////////////////////

	task automatic abortRun(input string why);
		$display("%s", why);
		$display("Test failed");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic checkClass(input string name, input roverPkg::beaconClassT actual,
			input roverPkg::beaconClassT expected);
		if (actual !== expected) begin
			abortRun($sformatf("mismatch %s: got 0x%0h, expected 0x%0h", name, actual, expected));
		end
	endtask

	task automatic checkWidth(input string name, input roverPkg::widthT actual,
			input roverPkg::widthT expected);
		if (actual !== expected) begin
			abortRun($sformatf("mismatch %s: got 0x%0h, expected 0x%0h", name, actual, expected));
		end
	endtask

	task automatic checkSegments(input string name, input logic [6:0] actual,
			input logic [6:0] expected);
		if (actual !== expected) begin
			abortRun($sformatf("mismatch %s: got 0x%0h, expected 0x%0h", name, actual, expected));
		end
	endtask

	////////////////////////////////////////////////////////////
	// Measurement helpers
	////////////////////////////////////////////////////////////

	// Transitions per window times the depth, against both thresholds
	function automatic roverPkg::beaconClassT classFromRule(input int half);
		int perWindow;
		int rate;
		perWindow = 0;
		if (half != 0) begin
			perWindow = TbWindow / half;
		end
		rate = perWindow * RateDepth;
		if (rate >= CloseLimit) begin
			classFromRule = roverPkg::ClassClose;
		end else if (rate > FarLimit) begin
			classFromRule = roverPkg::ClassFar;
		end else begin
			classFromRule = roverPkg::ClassNone;
		end
	endfunction

	task automatic waitWindows(input int count, input logic watchNone);
		int seen;
		int cycles;
		seen = 0;
		cycles = 0;
		while (seen < count) begin
			@(negedge clock);
			cycles++;
			if (UUT.windowDoneLeft) begin
				seen++;
			end
			if (watchNone) begin
				checkClass("classLeft", UUT.classLeft, roverPkg::ClassNone);
				checkClass("classRight", UUT.classRight, roverPkg::ClassNone);
			end
			if (cycles > (count + 2) * TbWindow) begin
				abortRun("timeout while waiting for the window strobe");
			end
		end
	endtask

	task automatic scanDisplay(input roverPkg::beaconClassT left,
			input roverPkg::beaconClassT right);
		logic [6:0] expected;
		logic [3:0] anodeCode;
		int cycles;
		for (int d = 0; d < 4; d++) begin
			anodeCode = ~(4'b0001 << d);
			cycles = 0;
			while (anodes !== anodeCode) begin
				@(negedge clock);
				cycles++;
				if (cycles > 4 * (1 << TbScan)) begin
					abortRun($sformatf("display never selected digit %0d", d));
				end
			end
			expected = roverPkg::SegBlank;
			if ((d == 0) && ((left == roverPkg::ClassClose) || (right == roverPkg::ClassClose))) begin
				expected = roverPkg::SegC;
			end
			if ((d == 1) && ((left == roverPkg::ClassFar) || (right == roverPkg::ClassFar))) begin
				expected = roverPkg::SegF;
			end
			checkSegments($sformatf("segments digit %0d", d), segments, expected);
		end
	endtask

	// One complete high pulse, counted on falling clock edges
	task automatic measurePulse(input logic isLeft, output roverPkg::widthT width);
		int cycles;
		cycles = 0;
		while ((isLeft ? servoLeft : servoRight) !== 1'b0) begin
			@(negedge clock);
			cycles++;
			if (cycles > TbPeriod + 4) begin
				abortRun("servo output stuck high");
			end
		end
		cycles = 0;
		while ((isLeft ? servoLeft : servoRight) !== 1'b1) begin
			@(negedge clock);
			cycles++;
			if (cycles > 2 * TbPeriod + 4) begin
				abortRun("servo output produced no pulse");
			end
		end
		width = '0;
		while ((isLeft ? servoLeft : servoRight) === 1'b1) begin
			width = width + 1'b1;
			@(negedge clock);
			if (width > TbPeriod + 4) begin
				abortRun("servo pulse never ended");
			end
		end
	endtask

	task automatic servoSettles(input string name, input logic isLeft,
			input roverPkg::widthT expected);
		roverPkg::widthT width;
		int tries;
		tries = 0;
		measurePulse(isLeft, width);
		while ((width !== expected) && (tries < MaxPulses)) begin
			measurePulse(isLeft, width);
			tries++;
		end
		checkWidth(name, width, expected);
	endtask

	////////////////////////////////////////////////////////////
	// Vector execution
	////////////////////////////////////////////////////////////

	task automatic runVector(input int hl, input int hr, input int windows,
			input int cl, input int cr, input int glitch);
		roverPkg::beaconClassT expLeft;
		roverPkg::beaconClassT expRight;
		roverPkg::widthT wantLeft;
		roverPkg::widthT wantRight;
		expLeft = roverPkg::beaconClassT'(cl[1:0]);
		expRight = roverPkg::beaconClassT'(cr[1:0]);
		if ((expLeft !== classFromRule(hl)) || (expRight !== classFromRule(hr))) begin
			abortRun($sformatf("vector %0d expects classes that break the rate rule",
				vectorCount));
		end
		@(negedge clock);
		halfLeft = hl;
		halfRight = hr;
		glitchMode = (glitch != 0);
		waitWindows(windows, glitchMode);
		// Class follows the strobe by two registers
		repeat (3) @(negedge clock);
		checkClass("classLeft", UUT.classLeft, expLeft);
		checkClass("classRight", UUT.classRight, expRight);
		scanDisplay(expLeft, expRight);
		wantLeft = TbRestLeft;
		wantRight = TbRestRight;
		if (expLeft == roverPkg::ClassClose) begin
			wantLeft = TbRestLeft + TbStep;
		end else if (expRight == roverPkg::ClassClose) begin
			wantRight = TbRestRight - TbStep;
		end
		servoSettles("servoLeft", 1'b1, wantLeft);
		servoSettles("servoRight", 1'b0, wantRight);
	endtask

	initial begin
		repeat (4) @(posedge clock);
		arstN <= 1'b1;
		fd = $fopen(VectorFile, "r");
		if (fd == 0) begin
			abortRun("cannot open the vector file");
		end
		while (!$feof(fd)) begin
			lineText = '0;
			if ($fgets(lineText, fd) != 0) begin
				// Comment and blank lines do not scan
				fields = $sscanf(lineText, "%d %d %d %d %d %d", vecHalfLeft, vecHalfRight,
					vecWindows, vecClassLeft, vecClassRight, vecGlitch);
				if (fields == 6) begin
					runVector(vecHalfLeft, vecHalfRight, vecWindows, vecClassLeft,
						vecClassRight, vecGlitch);
					vectorCount++;
				end
			end
		end
		$fclose(fd);
		if (vectorCount == 0) begin
			abortRun("the vector file held no test vectors");
		end else begin
			$display("Test completed successfully");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== verification/beaconShooter_vectors.txt ====
# halfLeft halfRight windows classLeft classRight glitch
# half-periods in clock cycles, 0 holds the level; classes 0 none, 1 far, 2 close
0 0 10 0 0 0
8 0 10 1 0 0
0 0 10 0 0 0
0 3 10 0 2 0
0 0 10 0 0 0
3 3 10 2 2 0
0 0 10 0 0 0
3 8 10 2 1 0
0 32 10 0 1 0
64 0 10 0 0 0
0 0 10 0 0 1
0 0 12 0 0 1

// ==== beaconShooter.f ====
common/roverPkg.sv
beacon/transitionCounter.sv
beacon/rateAverager.sv
shooter/fireSequencer.sv
shooter/servoPwm.sv
source/statusDisplay.sv
source/beaconShooter.sv
verification/beaconShooter_chk.sv
verification/beaconShooterTb.sv

// ==== Makefile ====
# Verilator build and run for the beacon shooter testbench

SIM      := verilator
TOP      := beaconShooterTb
FILELIST := beaconShooter.f
OBJDIR   := obj_dir
FLAGS    := --binary --timing --assert -Wno-fatal --Mdir $(OBJDIR) --top-module $(TOP)

SOURCES  := $(shell grep -v '^+' $(FILELIST))
BIN      := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) -f $(FILELIST)

# Exit status of the simulator is the test result
run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJDIR)
